// File: common/mux_join_pkg.sv
// Shared widths, depths, opcodes and helpers for the send-side join data path
package mux_join_pkg;

  // ----------------------------
  // Stream widths
  // ----------------------------

  // Payload width of every stream port
  localparam int DATA_BITS = 64;
  // One keep bit per data byte
  localparam int KEEP_BITS = DATA_BITS / 8;
  // Stream id, passed through untouched
  localparam int TID_BITS = 4;

  // ----------------------------
  // Request fields
  // ----------------------------

  // Beat count minus one
  localparam int LEN_BITS = 8;

  // ----------------------------
  // Buffer sizing
  // ----------------------------

  // Metadata queue toward the send queue
  localparam int META_DEPTH = 4;
  localparam int META_PTR_BITS = $clog2(META_DEPTH);
  // Occupancy needs one extra code for the full state
  localparam int META_CNT_BITS = $clog2(META_DEPTH + 1);

  // Outbound data FIFO
  localparam int DATA_DEPTH = 16;
  localparam int DATA_PTR_BITS = $clog2(DATA_DEPTH);
  localparam int DATA_CNT_BITS = $clog2(DATA_DEPTH + 1);

  // ----------------------------
  // Opcodes
  // ----------------------------

  // Work request opcode
  typedef enum logic [1:0] {
    // Payload comes back on the response stream
    OP_RD_REQ = 2'd0,
    // Local write payload from the receive stream
    OP_WRITE  = 2'd1,
    // Local send payload from the receive stream
    OP_SEND   = 2'd2
  } opcode_t;

  // True when the payload must be taken from the response stream
  function automatic logic is_rd_opcode(opcode_t op);
    logic rd;
    // Only read requests use remote data
    rd = (op == OP_RD_REQ);
    return rd;
  endfunction

endpackage

// File: src/meta_queue.sv
// Small synchronous FIFO holding the opcode and length of each accepted request
`timescale 1ns/1ps

module meta_queue (
  input  logic                                  aclk,
  input  logic                                  aresetn,
  input  logic                                  s_valid,
  output logic                                  s_ready,
  input  mux_join_pkg::opcode_t                 s_opcode,
  input  logic [mux_join_pkg::LEN_BITS-1:0]     s_len,
  output logic                                  m_valid,
  input  logic                                  m_ready,
  output mux_join_pkg::opcode_t                 m_opcode,
  output logic [mux_join_pkg::LEN_BITS-1:0]     m_len
);
  import mux_join_pkg::*;

  // Entry storage
  opcode_t              mem_opcode [META_DEPTH];
  logic [LEN_BITS-1:0]  mem_len    [META_DEPTH];

  // Pointers and occupancy
  logic [META_PTR_BITS-1:0] wr_ptr;
  logic [META_PTR_BITS-1:0] rd_ptr;
  logic [META_CNT_BITS-1:0] count;

  logic push;
  logic pop;

  // Full at META_DEPTH entries, empty at zero
  assign s_ready = (count != META_CNT_BITS'(META_DEPTH));
  assign m_valid = (count != '0);
  assign push    = s_valid & s_ready;
  assign pop     = m_valid & m_ready;

  // Head entry straight from the array
  assign m_opcode = mem_opcode[rd_ptr];
  assign m_len    = mem_len[rd_ptr];

  // Control state
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Wrap pointers at the last slot
      if (push) begin
        wr_ptr <= (wr_ptr == META_PTR_BITS'(META_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == META_PTR_BITS'(META_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count as is
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Write side of the array
  always_ff @(posedge aclk) begin
    if (push) begin
      mem_opcode[wr_ptr] <= s_opcode;
      mem_len[wr_ptr]    <= s_len;
    end
  end

endmodule

// File: src/axis_data_fifo.sv
// Stream data FIFO, register array that buffers data, keep, last and id beats
`timescale 1ns/1ps

module axis_data_fifo (
  input  logic                                  aclk,
  input  logic                                  aresetn,
  // Write side
  input  logic                                  s_tvalid,
  output logic                                  s_tready,
  input  logic [mux_join_pkg::DATA_BITS-1:0]    s_tdata,
  input  logic [mux_join_pkg::KEEP_BITS-1:0]    s_tkeep,
  input  logic                                  s_tlast,
  input  logic [mux_join_pkg::TID_BITS-1:0]     s_tid,
  // Read side
  output logic                                  m_tvalid,
  input  logic                                  m_tready,
  output logic [mux_join_pkg::DATA_BITS-1:0]    m_tdata,
  output logic [mux_join_pkg::KEEP_BITS-1:0]    m_tkeep,
  output logic                                  m_tlast,
  output logic [mux_join_pkg::TID_BITS-1:0]     m_tid
);
  import mux_join_pkg::*;

  // ----------------------------
  // Storage
  // ----------------------------

  // Beat payload, one slot per entry
  logic [DATA_BITS-1:0] mem_data [DATA_DEPTH];
  logic [KEEP_BITS-1:0] mem_keep [DATA_DEPTH];
  logic                 mem_last [DATA_DEPTH];
  logic [TID_BITS-1:0]  mem_tid  [DATA_DEPTH];

  // Pointers and fill level
  logic [DATA_PTR_BITS-1:0] wr_ptr;
  logic [DATA_PTR_BITS-1:0] rd_ptr;
  logic [DATA_CNT_BITS-1:0] count;

  logic wr_en;
  logic rd_en;

  // ----------------------------
  // Flags and handshakes
  // ----------------------------

  // Back-pressure once every slot is taken
  assign s_tready = (count != DATA_CNT_BITS'(DATA_DEPTH));
  assign m_tvalid = (count != '0);
  assign wr_en    = s_tvalid & s_tready;
  assign rd_en    = m_tvalid & m_tready;

  // Head beat, held while m_tready is low
  assign m_tdata = mem_data[rd_ptr];
  assign m_tkeep = mem_keep[rd_ptr];
  assign m_tlast = mem_last[rd_ptr];
  assign m_tid   = mem_tid[rd_ptr];

  // ----------------------------
  // Pointer and count update
  // ----------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == DATA_PTR_BITS'(DATA_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == DATA_PTR_BITS'(DATA_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Level moves only on a one-sided transfer
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  // Beat capture
  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem_data[wr_ptr] <= s_tdata;
      mem_keep[wr_ptr] <= s_tkeep;
      mem_last[wr_ptr] <= s_tlast;
      mem_tid[wr_ptr]  <= s_tid;
    end
  end

endmodule

// File: axis_mux_join/axis_mux_join.sv
// Request-driven join, grants the receive or response stream per request for len+1 beats
`timescale 1ns/1ps

module axis_mux_join (
  input  logic                                  aclk,
  input  logic                                  aresetn,
  // Work requests in
  input  logic                                  rq_valid,
  output logic                                  rq_ready,
  input  mux_join_pkg::opcode_t                 rq_opcode,
  input  logic [mux_join_pkg::LEN_BITS-1:0]     rq_len,
  // Forwarded requests toward the send queue
  output logic                                  sq_valid,
  input  logic                                  sq_ready,
  output mux_join_pkg::opcode_t                 sq_opcode,
  output logic [mux_join_pkg::LEN_BITS-1:0]     sq_len,
  // Locally sourced payload
  input  logic                                  recv_tvalid,
  output logic                                  recv_tready,
  input  logic [mux_join_pkg::DATA_BITS-1:0]    recv_tdata,
  input  logic [mux_join_pkg::KEEP_BITS-1:0]    recv_tkeep,
  input  logic                                  recv_tlast,
  input  logic [mux_join_pkg::TID_BITS-1:0]     recv_tid,
  // Read response payload
  input  logic                                  resp_tvalid,
  output logic                                  resp_tready,
  input  logic [mux_join_pkg::DATA_BITS-1:0]    resp_tdata,
  input  logic [mux_join_pkg::KEEP_BITS-1:0]    resp_tkeep,
  input  logic                                  resp_tlast,
  input  logic [mux_join_pkg::TID_BITS-1:0]     resp_tid,
  // Joined outbound stream
  output logic                                  out_tvalid,
  input  logic                                  out_tready,
  output logic [mux_join_pkg::DATA_BITS-1:0]    out_tdata,
  output logic [mux_join_pkg::KEEP_BITS-1:0]    out_tkeep,
  output logic                                  out_tlast,
  output logic [mux_join_pkg::TID_BITS-1:0]     out_tid
);
  import mux_join_pkg::*;

  // Join FSM
  typedef enum logic [0:0] {
    ST_IDLE = 1'b0,
    ST_MUX  = 1'b1
  } state_t;

  state_t state_q;
  state_t state_d;

  // Remaining beats minus one, and source select
  logic [LEN_BITS-1:0] cnt_q;
  logic [LEN_BITS-1:0] cnt_d;
  logic                rd_q;
  logic                rd_d;

  // Push side of the metadata queue
  logic q_valid;
  logic q_ready;

  // Muxed stream into the data FIFO
  logic                 mux_tvalid;
  logic                 mux_tready;
  logic [DATA_BITS-1:0] mux_tdata;
  logic [KEEP_BITS-1:0] mux_tkeep;
  logic                 mux_tlast;
  logic [TID_BITS-1:0]  mux_tid;

  logic beat;
  logic tr_done;
  logic accept;

  // ----------------------------
  // Source mux
  // ----------------------------
  always_comb begin
    mux_tvalid  = 1'b0;
    mux_tdata   = '0;
    mux_tkeep   = '0;
    mux_tlast   = 1'b0;
    mux_tid     = '0;
    recv_tready = 1'b0;
    resp_tready = 1'b0;
    if (state_q == ST_MUX) begin
      // Granted source only, other side stays stalled
      if (rd_q) begin
        mux_tvalid  = resp_tvalid;
        mux_tdata   = resp_tdata;
        mux_tkeep   = resp_tkeep;
        mux_tlast   = resp_tlast;
        mux_tid     = resp_tid;
        resp_tready = mux_tready;
      end else begin
        mux_tvalid  = recv_tvalid;
        mux_tdata   = recv_tdata;
        mux_tkeep   = recv_tkeep;
        mux_tlast   = recv_tlast;
        mux_tid     = recv_tid;
        recv_tready = mux_tready;
      end
    end
  end

  // ----------------------------
  // Request acceptance
  // ----------------------------

  // Beat moved into the FIFO
  assign beat    = mux_tvalid & mux_tready;
  // Last beat of the current grant
  assign tr_done = (state_q == ST_MUX) && (cnt_q == '0) && beat;
  // Free slot now or after this beat, plus room in the queue
  assign accept  = rq_valid & q_ready & ((state_q == ST_IDLE) | tr_done);

  assign rq_ready = accept;
  assign q_valid  = accept;

  // Next state and datapath
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    rd_d    = rd_q;
    if (accept) begin
      // Back-to-back grant, no dead cycle
      state_d = ST_MUX;
      cnt_d   = rq_len;
      rd_d    = is_rd_opcode(rq_opcode);
    end else if (tr_done) begin
      state_d = ST_IDLE;
    end else if (beat) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      rd_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      rd_q    <= rd_d;
    end
  end

  // ----------------------------
  // Queues
  // ----------------------------

  // Accepted requests on to the send queue
  meta_queue meta_queue_i (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .s_valid  (q_valid),
    .s_ready  (q_ready),
    .s_opcode (rq_opcode),
    .s_len    (rq_len),
    .m_valid  (sq_valid),
    .m_ready  (sq_ready),
    .m_opcode (sq_opcode),
    .m_len    (sq_len)
  );

  // Absorbs short out_tready stalls
  axis_data_fifo axis_data_fifo_i (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .s_tvalid (mux_tvalid),
    .s_tready (mux_tready),
    .s_tdata  (mux_tdata),
    .s_tkeep  (mux_tkeep),
    .s_tlast  (mux_tlast),
    .s_tid    (mux_tid),
    .m_tvalid (out_tvalid),
    .m_tready (out_tready),
    .m_tdata  (out_tdata),
    .m_tkeep  (out_tkeep),
    .m_tlast  (out_tlast),
    .m_tid    (out_tid)
  );

endmodule

// File: src/sq_join_top.sv
// Top level of the send-side join, exposes request, send queue and stream ports
`timescale 1ns/1ps

module sq_join_top (
  input  logic                                  aclk,
  input  logic                                  aresetn,
  // Requests
  input  logic                                  rq_valid,
  output logic                                  rq_ready,
  input  mux_join_pkg::opcode_t                 rq_opcode,
  input  logic [mux_join_pkg::LEN_BITS-1:0]     rq_len,
  // Send queue
  output logic                                  sq_valid,
  input  logic                                  sq_ready,
  output mux_join_pkg::opcode_t                 sq_opcode,
  output logic [mux_join_pkg::LEN_BITS-1:0]     sq_len,
  // Receive stream
  input  logic                                  recv_tvalid,
  output logic                                  recv_tready,
  input  logic [mux_join_pkg::DATA_BITS-1:0]    recv_tdata,
  input  logic [mux_join_pkg::KEEP_BITS-1:0]    recv_tkeep,
  input  logic                                  recv_tlast,
  input  logic [mux_join_pkg::TID_BITS-1:0]     recv_tid,
  // Response stream
  input  logic                                  resp_tvalid,
  output logic                                  resp_tready,
  input  logic [mux_join_pkg::DATA_BITS-1:0]    resp_tdata,
  input  logic [mux_join_pkg::KEEP_BITS-1:0]    resp_tkeep,
  input  logic                                  resp_tlast,
  input  logic [mux_join_pkg::TID_BITS-1:0]     resp_tid,
  // Outbound stream
  output logic                                  out_tvalid,
  input  logic                                  out_tready,
  output logic [mux_join_pkg::DATA_BITS-1:0]    out_tdata,
  output logic [mux_join_pkg::KEEP_BITS-1:0]    out_tkeep,
  output logic                                  out_tlast,
  output logic [mux_join_pkg::TID_BITS-1:0]     out_tid
);

  // Single join instance, names match one to one
  axis_mux_join axis_mux_join_i (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .rq_valid    (rq_valid),
    .rq_ready    (rq_ready),
    .rq_opcode   (rq_opcode),
    .rq_len      (rq_len),
    .sq_valid    (sq_valid),
    .sq_ready    (sq_ready),
    .sq_opcode   (sq_opcode),
    .sq_len      (sq_len),
    .recv_tvalid (recv_tvalid),
    .recv_tready (recv_tready),
    .recv_tdata  (recv_tdata),
    .recv_tkeep  (recv_tkeep),
    .recv_tlast  (recv_tlast),
    .recv_tid    (recv_tid),
    .resp_tvalid (resp_tvalid),
    .resp_tready (resp_tready),
    .resp_tdata  (resp_tdata),
    .resp_tkeep  (resp_tkeep),
    .resp_tlast  (resp_tlast),
    .resp_tid    (resp_tid),
    .out_tvalid  (out_tvalid),
    .out_tready  (out_tready),
    .out_tdata   (out_tdata),
    .out_tkeep   (out_tkeep),
    .out_tlast   (out_tlast),
    .out_tid     (out_tid)
  );

endmodule

// File: dv/sq_join_props.sv
// Bound checks on the join FSM, grant exclusivity and the send-queue hold rule
`timescale 1ns/1ps

module sq_join_props (
  input logic aclk,
  input logic aresetn,
  input logic idle,
  input logic mux_tvalid,
  input logic recv_tready,
  input logic resp_tready,
  input logic sq_valid,
  input logic sq_ready,
  input logic [1:0] sq_opcode,
  input logic [mux_join_pkg::LEN_BITS-1:0] sq_len
);

  // Count of assertion failures
  int fail_count = 0;

  // ------------------------------
  // FSM and grant
  // ------------------------------

  // Nothing reaches the FIFO while idle
  a_idle_quiet: assert property (@(posedge aclk) disable iff (!aresetn)
    idle |-> !mux_tvalid)
    else begin
      fail_count++;
      $error("join drives the data FIFO while idle");
    end

  // One source at a time
  a_one_ready: assert property (@(posedge aclk) disable iff (!aresetn)
    !(recv_tready && resp_tready))
    else begin
      fail_count++;
      $error("recv and resp tready high together");
    end

  // Stalled send-queue entry holds
  a_sq_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    (sq_valid && !sq_ready) |=> (sq_valid && $stable(sq_opcode) && $stable(sq_len)))
    else begin
      fail_count++;
      $error("send-queue entry changed while stalled");
    end

endmodule

bind axis_mux_join sq_join_props sq_join_props_i (
  .aclk        (aclk),
  .aresetn     (aresetn),
  .idle        (state_q == ST_IDLE),
  .mux_tvalid  (mux_tvalid),
  .recv_tready (recv_tready),
  .resp_tready (resp_tready),
  .sq_valid    (sq_valid),
  .sq_ready    (sq_ready),
  .sq_opcode   (sq_opcode),
  .sq_len      (sq_len)
);

// File: dv/sq_join_tb.sv
// Send-side join testbench with random requests and streams checked against a model
`timescale 1ns/1ps

module sq_join_tb;
  import mux_join_pkg::*;

  localparam int NUM_REQS    = 40;
  localparam int WAIT_LIMIT  = 4000;
  localparam int DONE_LIMIT  = 40000;

  // One stream beat with all sideband bits
  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic [KEEP_BITS-1:0] keep;
    logic                 last;
    logic [TID_BITS-1:0]  tid;
  } beat_t;

  logic aclk;
  logic aresetn;
  logic rq_valid, rq_ready, sq_valid, sq_ready;
  opcode_t rq_opcode, sq_opcode;
  logic [LEN_BITS-1:0] rq_len, sq_len;
  logic recv_tvalid, recv_tready, recv_tlast, resp_tvalid, resp_tready, resp_tlast;
  logic [DATA_BITS-1:0] recv_tdata, resp_tdata, out_tdata;
  logic [KEEP_BITS-1:0] recv_tkeep, resp_tkeep, out_tkeep;
  logic [TID_BITS-1:0] recv_tid, resp_tid, out_tid;
  logic out_tvalid, out_tready, out_tlast;

  // Planned stimulus and model queues
  opcode_t             req_op_q[$];
  logic [LEN_BITS-1:0] req_len_q[$];
  beat_t               recv_q[$];
  beat_t               resp_q[$];
  beat_t               exp_q[$];
  bit                  grant_q[$];
  opcode_t             acc_op_q[$];
  logic [LEN_BITS-1:0] acc_len_q[$];

  beat_t exp_beat;
  beat_t got_beat;
  opcode_t exp_op;
  logic [LEN_BITS-1:0] exp_len;
  int total_beats, out_count, sq_count, grant_idx, wait_cnt;
  int reset_errors, data_errors, sq_errors, grant_errors, timeout_errors, prop_errors;

  sq_join_top sq_join_top_i (.*);

  // 8 ns clock
  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  // ------------------------------
  // Stimulus helpers
  // ------------------------------

  // Model of requests in order with len+1 beats from the chosen source
  task automatic build_stimulus();
    opcode_t op;
    int len;
    bit rd;
    beat_t b;
    for (int i = 0; i < NUM_REQS; i++) begin
      op = opcode_t'(2'($urandom_range(0, 2)));
      len = $urandom_range(0, 7);
      // Read requests are answered on the response stream
      rd = (op == OP_RD_REQ);
      req_op_q.push_back(op);
      req_len_q.push_back(LEN_BITS'(len));
      for (int k = 0; k <= len; k++) begin
        b.data = {$urandom, $urandom};
        b.keep = KEEP_BITS'($urandom);
        b.last = (k == len);
        b.tid  = TID_BITS'(i % 16);
        if (rd) resp_q.push_back(b);
        else recv_q.push_back(b);
        exp_q.push_back(b);
        grant_q.push_back(rd);
      end
    end
    total_beats = exp_q.size();
  endtask

  task automatic set_source(input bit rd, input logic valid, input beat_t b);
    if (rd) begin
      resp_tvalid = valid;
      resp_tdata  = b.data;
      resp_tkeep  = b.keep;
      resp_tlast  = b.last;
      resp_tid    = b.tid;
    end else begin
      recv_tvalid = valid;
      recv_tdata  = b.data;
      recv_tkeep  = b.keep;
      recv_tlast  = b.last;
      recv_tid    = b.tid;
    end
  endtask

  task automatic drive_requests();
    int gap;
    int cnt;
    for (int i = 0; i < NUM_REQS; i++) begin
      gap = $urandom_range(0, 3);
      @(negedge aclk);
      if (gap > 0) begin
        rq_valid = 1'b0;
        repeat (gap) @(negedge aclk);
      end
      rq_valid  = 1'b1;
      rq_opcode = req_op_q[i];
      rq_len    = req_len_q[i];
      cnt = 0;
      @(posedge aclk);
      while (!rq_ready && cnt < WAIT_LIMIT) begin
        @(posedge aclk);
        cnt++;
      end
      if (!rq_ready) begin
        timeout_errors++;
        $display("Request %0d was never accepted by the join", i);
        return;
      end
    end
    @(negedge aclk);
    rq_valid = 1'b0;
  endtask

  // Sends the planned beats of one source and holds each until taken
  task automatic drive_source(input bit rd);
    beat_t b;
    int n;
    int gap;
    int cnt;
    n = rd ? resp_q.size() : recv_q.size();
    for (int k = 0; k < n; k++) begin
      b = rd ? resp_q[k] : recv_q[k];
      gap = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : 0;
      @(negedge aclk);
      if (gap > 0) begin
        set_source(rd, 1'b0, '0);
        repeat (gap) @(negedge aclk);
      end
      set_source(rd, 1'b1, b);
      cnt = 0;
      @(posedge aclk);
      while (!(rd ? resp_tready : recv_tready) && cnt < WAIT_LIMIT) begin
        @(posedge aclk);
        cnt++;
      end
      if (!(rd ? resp_tready : recv_tready)) begin
        timeout_errors++;
        $display("Source beat %0d (response=%0d) was never taken", k, rd);
        return;
      end
    end
    @(negedge aclk);
    set_source(rd, 1'b0, '0);
  endtask

  // ------------------------------
  // Monitors at the rising edge
  // ------------------------------
  always @(posedge aclk) begin
    if (aresetn) begin
      if (out_tvalid && out_tready) begin
        if (exp_q.size() == 0) begin
          data_errors++;
          $display("Output beat at %0t has no expected beat left", $time);
        end else begin
          exp_beat = exp_q.pop_front();
          got_beat = {out_tdata, out_tkeep, out_tlast, out_tid};
          if (got_beat !== exp_beat) begin
            data_errors++;
            $display("CHECK FAILED @%0t: beat %0d got %h %h %b %h, expected %h %h %b %h",
                     $time, out_count, out_tdata, out_tkeep, out_tlast, out_tid,
                     exp_beat.data, exp_beat.keep, exp_beat.last, exp_beat.tid);
          end
          out_count++;
        end
      end
      // Send queue follows acceptance order
      if (sq_valid && sq_ready) begin
        if (acc_op_q.size() == 0) begin
          sq_errors++;
          $display("Send queue entry at %0t without an accepted request", $time);
        end else begin
          exp_op  = acc_op_q.pop_front();
          exp_len = acc_len_q.pop_front();
          if (sq_opcode !== exp_op || sq_len !== exp_len) begin
            sq_errors++;
            $display("CHECK FAILED @%0t: sq entry %0d got %0d/%0d, expected %0d/%0d",
                     $time, sq_count, sq_opcode, sq_len, exp_op, exp_len);
          end
          sq_count++;
        end
      end
      if (rq_valid && rq_ready) begin
        acc_op_q.push_back(rq_opcode);
        acc_len_q.push_back(rq_len);
      end
      // Only the granted source may see tready
      if (recv_tready && resp_tready) begin
        grant_errors++;
        $display("CHECK FAILED @%0t: both sources see tready high", $time);
      end else if (recv_tready || resp_tready) begin
        if (grant_idx >= grant_q.size()) begin
          grant_errors++;
          $display("A source saw tready at %0t after all beats were moved", $time);
        end else begin
          if (resp_tready != grant_q[grant_idx]) begin
            grant_errors++;
            $display("CHECK FAILED @%0t: tready on wrong source for beat %0d",
                     $time, grant_idx);
          end
          if ((recv_tready && recv_tvalid) || (resp_tready && resp_tvalid)) grant_idx++;
        end
      end
    end
  end

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    aresetn = 1'b0;
    rq_valid = 1'b0;
    rq_opcode = OP_WRITE;
    rq_len = '0;
    sq_ready = 1'b0;
    out_tready = 1'b0;
    set_source(1'b0, 1'b0, '0);
    set_source(1'b1, 1'b0, '0);
    void'($urandom(32'h229c));
    build_stimulus();
    repeat (3) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
    if (rq_ready || sq_valid || recv_tready || resp_tready || out_tvalid) begin
      reset_errors++;
      $display("CHECK FAILED @%0t: outputs not low after reset", $time);
    end
    fork
      drive_requests();
      drive_source(1'b0);
      drive_source(1'b1);
      // Random downstream stalls
      forever begin
        @(negedge aclk);
        out_tready = ($urandom_range(0, 3) != 0);
        sq_ready   = ($urandom_range(0, 2) != 0);
      end
    join_none
    wait_cnt = 0;
    while ((out_count < total_beats || sq_count < NUM_REQS) && wait_cnt < DONE_LIMIT) begin
      @(posedge aclk);
      wait_cnt++;
    end
    if (out_count < total_beats || sq_count < NUM_REQS) begin
      timeout_errors++;
      $display("Run timed out with %0d of %0d beats and %0d of %0d entries",
               out_count, total_beats, sq_count, NUM_REQS);
    end
    // Short drain window to catch duplicated beats
    repeat (20) @(posedge aclk);
    if (out_count != total_beats || exp_q.size() != 0) begin
      data_errors++;
      $display("CHECK FAILED @%0t: %0d beats out, model expects %0d",
               $time, out_count, total_beats);
    end
    prop_errors = sq_join_top_i.axis_mux_join_i.sq_join_props_i.fail_count;
    $display("Errors: reset %0d, data %0d, send queue %0d, grant %0d, assertion %0d, timeout %0d",
             reset_errors, data_errors, sq_errors, grant_errors, prop_errors, timeout_errors);
    if (reset_errors + data_errors + sq_errors + grant_errors + prop_errors
        + timeout_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: files.f
common/mux_join_pkg.sv
src/meta_queue.sv
src/axis_data_fifo.sv
axis_mux_join/axis_mux_join.sv
src/sq_join_top.sv
dv/sq_join_props.sv
dv/sq_join_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the join testbench with Verilator, pass only on the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module sq_join_tb \
  -Mdir obj_dir -f files.f || exit 1
result=$(./obj_dir/Vsq_join_tb 2>&1)
printf '%s\n' "$result"
printf '%s\n' "$result" | grep -qx "Simulation completed successfully" && exit 0 || exit 1
